// ==== decode_tests.txt ====
// instruction pc_plus4 stall flush wb_write wb_addr wb_data exp_execute exp_memory exp_writeback
// All hex; expected buses are the raw decode, before flush and stall
00000000 00000004 0 0 1 01 11111111 180 000 2
00000000 00000008 0 0 1 02 22222222 180 000 2
00000000 0000000c 0 0 1 04 44444444 180 000 2
00000000 00000010 0 0 1 05 55555555 180 000 2
00000000 00000014 0 0 1 1f 1f1f1f1f 180 000 2
00000000 00000018 0 0 1 00 deadbeef 180 000 2
00221820 0000001c 0 0 1 03 33333333 106 000 2
00612022 00000020 0 0 1 03 0badf00d 107 000 2
00222824 00000024 0 0 0 00 00000000 108 000 2
00222825 00000028 0 0 0 00 00000000 109 000 2
00222826 0000002c 0 0 0 00 00000000 10a 000 2
00222827 00000030 0 0 0 00 00000000 10b 000 2
0022282a 00000034 0 0 0 00 00000000 10c 000 2
00643021 00000038 0 0 0 00 00000000 106 000 2
00643023 0000003c 0 0 0 00 00000000 107 000 2
00023940 00000040 0 0 0 00 00000000 180 000 2
000547c2 00000044 0 0 0 00 00000000 181 000 2
001f4843 00000048 0 0 0 00 00000000 182 000 2
00225004 0000004c 0 0 0 00 00000000 103 000 2
00225006 00000050 0 0 0 00 00000000 104 000 2
00225007 00000054 0 0 0 00 00000000 105 000 2
03e00008 00000058 0 0 0 00 00000000 016 000 0
0080f809 0000005c 0 0 0 00 00000000 516 000 2
0022183f 00000060 0 0 0 00 00000000 106 000 2
8022fffc 00000064 0 0 0 00 00000000 046 022 3
84220010 00000068 0 0 0 00 00000000 046 012 3
8c228000 0000006c 0 0 0 00 00000000 046 002 3
90227fff 00000070 0 0 0 00 00000000 046 02a 3
94220002 00000074 0 0 0 00 00000000 046 01a 3
9c220004 00000078 0 0 0 00 00000000 046 002 3
a3e50001 0000007c 0 0 0 00 00000000 046 081 0
a7e5fffe 00000080 0 0 0 00 00000000 046 041 0
afe50100 00000084 0 0 0 00 00000000 046 001 0
20438001 00000088 0 0 0 00 00000000 046 004 2
304300ff 0000008c 0 0 0 00 00000000 048 004 2
34430f0f 00000090 0 0 0 00 00000000 049 004 2
3843ffff 00000094 0 0 0 00 00000000 04a 004 2
3c431234 00000098 0 0 0 00 00000000 04d 004 2
2843fff0 0000009c 0 0 0 00 00000000 04c 000 2
10220010 000000a0 0 0 0 00 00000000 00c 004 0
1422fff8 000000a4 0 0 0 00 00000000 00c 104 0
08000100 000000a8 0 0 0 00 00000000 020 004 0
0c000040 000000ac 0 0 0 00 00000000 626 000 2
fc221800 000000b0 0 0 0 00 00000000 000 000 0
44223040 000000b4 0 0 0 00 00000000 000 000 0
00221820 000000b8 0 1 0 00 00000000 106 000 2
00612022 000000bc 1 0 0 00 00000000 107 000 2
00222825 000000c0 1 0 1 01 a5a5a5a5 109 000 2
8022fffc 000000c4 1 1 0 00 00000000 046 022 3
00221820 000000c8 0 0 0 00 00000000 106 000 2

// ==== sim.f ====
decode_pkg.sv
alu_control.sv
control.sv
register_file.sv
id_ex_register.sv
instruction_decode.sv
decode_properties.sv
tb_instruction_decode.sv

// ==== tb_instruction_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_instruction_decode;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 10;
	localparam int FIELDS       = 10; // Words per vector line
	localparam int MAX_VECTORS  = 128;
	localparam int RESET_CYCLES = 2;

	logic                  clk;
	logic                  rst_n;
	decode_pkg::word_t     instruction;
	decode_pkg::word_t     pc_plus4;
	logic                  stall;
	logic                  flush;
	logic                  wb_write;
	decode_pkg::reg_addr_t wb_addr;
	decode_pkg::word_t     wb_data;
	decode_pkg::exec_bus_t ex_execute_bus;
	decode_pkg::mem_bus_t  ex_memory_bus;
	decode_pkg::wb_bus_t   ex_writeback_bus;
	decode_pkg::word_t     ex_rs_data;
	decode_pkg::word_t     ex_rt_data;
	decode_pkg::word_t     ex_pc_plus4;
	decode_pkg::word_t     ex_immediate;
	decode_pkg::reg_addr_t ex_rt;
	decode_pkg::reg_addr_t ex_rd;
	decode_pkg::reg_addr_t ex_shamt;

	decode_pkg::word_t vectors [0:FIELDS*MAX_VECTORS-1];
	decode_pkg::word_t reg_model [0:decode_pkg::N_REGS-1]; // Expected register contents

	// Expected ex_ outputs
	decode_pkg::exec_bus_t exp_execute_bus;
	decode_pkg::mem_bus_t  exp_memory_bus;
	decode_pkg::wb_bus_t   exp_writeback_bus;
	decode_pkg::word_t     exp_rs_data;
	decode_pkg::word_t     exp_rt_data;
	decode_pkg::word_t     exp_pc_plus4;
	decode_pkg::word_t     exp_immediate;
	decode_pkg::reg_addr_t exp_rt;
	decode_pkg::reg_addr_t exp_rd;
	decode_pkg::reg_addr_t exp_shamt;

	int          num_vectors;
	int          error_count;
	int          check_count;
	int          cycle_count = 0;
	int          cycle_limit = 1000; // Replaced once the vectors are counted
	logic [31:0] lcg_state;

	instruction_decode DUT (
		.clk              (clk),
		.rst_n            (rst_n),
		.instruction      (instruction),
		.pc_plus4         (pc_plus4),
		.stall            (stall),
		.flush            (flush),
		.wb_write         (wb_write),
		.wb_addr          (wb_addr),
		.wb_data          (wb_data),
		.ex_execute_bus   (ex_execute_bus),
		.ex_memory_bus    (ex_memory_bus),
		.ex_writeback_bus (ex_writeback_bus),
		.ex_rs_data       (ex_rs_data),
		.ex_rt_data       (ex_rt_data),
		.ex_pc_plus4      (ex_pc_plus4),
		.ex_immediate     (ex_immediate),
		.ex_rt            (ex_rt),
		.ex_rd            (ex_rd),
		.ex_shamt         (ex_shamt)
	);

	bind instruction_decode decode_properties u_decode_properties (
		.clk              (clk),
		.rst_n            (rst_n),
		.stall            (stall),
		.flush            (flush),
		.ex_execute_bus   (ex_execute_bus),
		.ex_memory_bus    (ex_memory_bus),
		.ex_writeback_bus (ex_writeback_bus),
		.ex_rs_data       (ex_rs_data),
		.ex_rt_data       (ex_rt_data),
		.ex_pc_plus4      (ex_pc_plus4),
		.ex_immediate     (ex_immediate),
		.ex_rt            (ex_rt),
		.ex_rd            (ex_rd),
		.ex_shamt         (ex_shamt)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD/2) clk = ~clk;
		end
	end

	// Run limit
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: the run did not end within %0d cycles", cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic compare_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic verify_outputs();
		compare_field("ex_execute_bus", ex_execute_bus, exp_execute_bus);
		compare_field("ex_memory_bus", ex_memory_bus, exp_memory_bus);
		compare_field("ex_writeback_bus", ex_writeback_bus, exp_writeback_bus);
		compare_field("ex_rs_data", ex_rs_data, exp_rs_data);
		compare_field("ex_rt_data", ex_rt_data, exp_rt_data);
		compare_field("ex_pc_plus4", ex_pc_plus4, exp_pc_plus4);
		compare_field("ex_immediate", ex_immediate, exp_immediate);
		compare_field("ex_rt", ex_rt, exp_rt);
		compare_field("ex_rd", ex_rd, exp_rd);
		compare_field("ex_shamt", ex_shamt, exp_shamt);
	endtask

	// Drives one line and predicts the outputs after the next edge
	task automatic apply_vector(input int idx);
		int                base;
		decode_pkg::word_t instr;
		base        = idx * FIELDS;
		instr       = vectors[base];
		instruction = instr;
		pc_plus4    = vectors[base+1];
		stall       = vectors[base+2][0];
		flush       = vectors[base+3][0];
		wb_write    = vectors[base+4][0];
		wb_addr     = vectors[base+5][4:0];
		wb_data     = vectors[base+6] ^ next_random(); // File pattern mixed with random
		if (flush || !stall)
		begin
			exp_execute_bus   = flush ? '0 : vectors[base+7][decode_pkg::LEN_EXEC_BUS-1:0];
			exp_memory_bus    = flush ? '0 : vectors[base+8][decode_pkg::LEN_MEM_BUS-1:0];
			exp_writeback_bus = flush ? '0 : vectors[base+9][decode_pkg::LEN_WB_BUS-1:0];
			exp_rs_data       = reg_model[instr[25:21]]; // Old contents, no bypass
			exp_rt_data       = reg_model[instr[20:16]];
			exp_pc_plus4      = vectors[base+1];
			exp_immediate     = instr[15] ? {16'hffff, instr[15:0]} : {16'h0000, instr[15:0]};
			exp_rt            = instr[20:16];
			exp_rd            = instr[15:11];
			exp_shamt         = instr[10:6];
		end
		// Write lands at the same edge
		if (wb_write && (wb_addr != 5'd0))
			reg_model[wb_addr] = wb_data;
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial
	begin
		instruction = '0;
		pc_plus4    = '0;
		stall       = 1'b0;
		flush       = 1'b0;
		wb_write    = 1'b0;
		wb_addr     = '0;
		wb_data     = '0;
		rst_n       = 1'b0;
		error_count = 0;
		check_count = 0;
		num_vectors = 0;
		lcg_state   = 32'd8;
		for (int r = 0; r < decode_pkg::N_REGS; r++)
			reg_model[r] = '0;
		exp_execute_bus   = '0; // Everything zero after reset
		exp_memory_bus    = '0;
		exp_writeback_bus = '0;
		exp_rs_data       = '0;
		exp_rt_data       = '0;
		exp_pc_plus4      = '0;
		exp_immediate     = '0;
		exp_rt            = '0;
		exp_rd            = '0;
		exp_shamt         = '0;

		for (int v = 0; v < FIELDS*MAX_VECTORS; v++)
			vectors[v] = '1; // Marks words the file leaves unset
		$readmemh("decode_tests.txt", vectors);
		// Stall column is 0 or 1 on every real line
		while ((num_vectors < MAX_VECTORS) && (vectors[num_vectors*FIELDS+2] <= 32'd1))
			num_vectors++;
		cycle_limit = num_vectors + 20;
		if (num_vectors == 0)
		begin
			$display("No test vectors could be read from decode_tests.txt");
			error_count++;
		end

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		verify_outputs();

		for (int i = 0; i < num_vectors; i++)
		begin
			apply_vector(i);
			@(posedge clk);
			#DRIVE_DELAY;
			verify_outputs();
		end

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== decode_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_properties (
	input wire                         clk,
	input wire                         rst_n,
	input wire                         stall,
	input wire                         flush,
	input wire decode_pkg::exec_bus_t  ex_execute_bus,
	input wire decode_pkg::mem_bus_t   ex_memory_bus,
	input wire decode_pkg::wb_bus_t    ex_writeback_bus,
	input wire decode_pkg::word_t      ex_rs_data,
	input wire decode_pkg::word_t      ex_rt_data,
	input wire decode_pkg::word_t      ex_pc_plus4,
	input wire decode_pkg::word_t      ex_immediate,
	input wire decode_pkg::reg_addr_t  ex_rt,
	input wire decode_pkg::reg_addr_t  ex_rd,
	input wire decode_pkg::reg_addr_t  ex_shamt
);

	wire         controls_zero = (ex_execute_bus == '0) && (ex_memory_bus == '0) &&
		(ex_writeback_bus == '0);
	wire [164:0] bundle = {ex_execute_bus, ex_memory_bus, ex_writeback_bus, ex_rs_data,
		ex_rt_data, ex_pc_plus4, ex_immediate, ex_rt, ex_rd, ex_shamt};

	reset_clears: assert property (@(posedge clk) !rst_n |=> (bundle == '0))
		else $error("ex_ outputs not cleared by reset");

	flush_bubble: assert property (@(posedge clk) (rst_n && flush) |=> controls_zero)
		else $error("Control buses not zero after flush");

	// Stall without flush freezes the stage
	stall_holds: assert property (@(posedge clk) (rst_n && stall && !flush) |=> $stable(bundle))
		else $error("ex_ outputs changed during stall");

endmodule

`default_nettype wire

// ==== instruction_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module instruction_decode (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire decode_pkg::word_t      instruction,
	input  wire decode_pkg::word_t      pc_plus4,
	input  wire                         stall,
	input  wire                         flush,
	input  wire                         wb_write,
	input  wire decode_pkg::reg_addr_t  wb_addr,
	input  wire decode_pkg::word_t      wb_data,
	output decode_pkg::exec_bus_t       ex_execute_bus,
	output decode_pkg::mem_bus_t        ex_memory_bus,
	output decode_pkg::wb_bus_t         ex_writeback_bus,
	output decode_pkg::word_t           ex_rs_data,
	output decode_pkg::word_t           ex_rt_data,
	output decode_pkg::word_t           ex_pc_plus4,
	output decode_pkg::word_t           ex_immediate,
	output decode_pkg::reg_addr_t       ex_rt,
	output decode_pkg::reg_addr_t       ex_rd,
	output decode_pkg::reg_addr_t       ex_shamt
);

	////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////
	wire decode_pkg::opcode_t   opcode = instruction[31:26];
	wire decode_pkg::reg_addr_t rs     = instruction[25:21];
	wire decode_pkg::reg_addr_t rt     = instruction[20:16];
	wire decode_pkg::reg_addr_t rd     = instruction[15:11];
	wire decode_pkg::reg_addr_t shamt  = instruction[10:6];
	wire decode_pkg::funct_t    funct  = instruction[5:0];
	wire [15:0]                 imm    = instruction[15:0];

	wire decode_pkg::exec_bus_t execute_bus;
	wire decode_pkg::mem_bus_t  memory_bus;
	wire decode_pkg::wb_bus_t   writeback_bus;
	wire decode_pkg::word_t     rs_data;
	wire decode_pkg::word_t     rt_data;

	control u_control (
		.opcode        (opcode),
		.funct         (funct),
		.execute_bus   (execute_bus),
		.memory_bus    (memory_bus),
		.writeback_bus (writeback_bus)
	);

	register_file u_register_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs_addr  (rs),
		.rt_addr  (rt),
		.wb_write (wb_write),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data),
		.rs_data  (rs_data),
		.rt_data  (rt_data)
	);

	// Everything toward execute goes through here
	id_ex_register u_id_ex_register (
		.clk              (clk),
		.rst_n            (rst_n),
		.stall            (stall),
		.flush            (flush),
		.execute_bus      (execute_bus),
		.memory_bus       (memory_bus),
		.writeback_bus    (writeback_bus),
		.rs_data          (rs_data),
		.rt_data          (rt_data),
		.pc_plus4         (pc_plus4),
		.rt               (rt),
		.rd               (rd),
		.shamt            (shamt),
		.imm              (imm),
		.ex_execute_bus   (ex_execute_bus),
		.ex_memory_bus    (ex_memory_bus),
		.ex_writeback_bus (ex_writeback_bus),
		.ex_rs_data       (ex_rs_data),
		.ex_rt_data       (ex_rt_data),
		.ex_pc_plus4      (ex_pc_plus4),
		.ex_immediate     (ex_immediate),
		.ex_rt            (ex_rt),
		.ex_rd            (ex_rd),
		.ex_shamt         (ex_shamt)
	);

endmodule

`default_nettype wire

// ==== id_ex_register.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_ex_register (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         stall,
	input  wire                         flush,
	input  wire decode_pkg::exec_bus_t  execute_bus,
	input  wire decode_pkg::mem_bus_t   memory_bus,
	input  wire decode_pkg::wb_bus_t    writeback_bus,
	input  wire decode_pkg::word_t      rs_data,
	input  wire decode_pkg::word_t      rt_data,
	input  wire decode_pkg::word_t      pc_plus4,
	input  wire decode_pkg::reg_addr_t  rt,
	input  wire decode_pkg::reg_addr_t  rd,
	input  wire decode_pkg::reg_addr_t  shamt,
	input  wire [15:0]                  imm,
	output decode_pkg::exec_bus_t       ex_execute_bus,
	output decode_pkg::mem_bus_t        ex_memory_bus,
	output decode_pkg::wb_bus_t         ex_writeback_bus,
	output decode_pkg::word_t           ex_rs_data,
	output decode_pkg::word_t           ex_rt_data,
	output decode_pkg::word_t           ex_pc_plus4,
	output decode_pkg::word_t           ex_immediate,
	output decode_pkg::reg_addr_t       ex_rt,
	output decode_pkg::reg_addr_t       ex_rd,
	output decode_pkg::reg_addr_t       ex_shamt
);

	decode_pkg::word_t imm_ext;

	assign imm_ext = {{16{imm[15]}}, imm}; // Sign extend

	////////////////////////////////////////
	// Pipeline register
	////////////////////////////////////////
	// Flush beats stall
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ex_execute_bus   <= '0;
			ex_memory_bus    <= '0;
			ex_writeback_bus <= '0;
			ex_rs_data       <= '0;
			ex_rt_data       <= '0;
			ex_pc_plus4      <= '0;
			ex_immediate     <= '0;
			ex_rt            <= '0;
			ex_rd            <= '0;
			ex_shamt         <= '0;
		end
		else if (flush || !stall)
		begin
			// Bubble on flush
			ex_execute_bus   <= flush ? '0 : execute_bus;
			ex_memory_bus    <= flush ? '0 : memory_bus;
			ex_writeback_bus <= flush ? '0 : writeback_bus;
			ex_rs_data       <= rs_data;
			ex_rt_data       <= rt_data;
			ex_pc_plus4      <= pc_plus4;
			ex_immediate     <= imm_ext;
			ex_rt            <= rt;
			ex_rd            <= rd;
			ex_shamt         <= shamt;
		end
	end

endmodule

`default_nettype wire

// ==== register_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire decode_pkg::reg_addr_t  rs_addr,
	input  wire decode_pkg::reg_addr_t  rt_addr,
	input  wire                         wb_write,
	input  wire decode_pkg::reg_addr_t  wb_addr,
	input  wire decode_pkg::word_t      wb_data,
	output decode_pkg::word_t           rs_data,
	output decode_pkg::word_t           rt_data
);

	// Register 0 has no storage
	decode_pkg::word_t regs [1:decode_pkg::N_REGS-1];

	////////////////////////////////////////
	// Write port
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 1; i < decode_pkg::N_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wb_write && (wb_addr != '0))
		begin
			regs[wb_addr] <= wb_data;
		end
	end

	////////////////////////////////////////
	// Read ports
	////////////////////////////////////////
	// Old value on a same-cycle write
	always_comb
	begin
		rs_data = '0;
		rt_data = '0;
		if (rs_addr != '0)
			rs_data = regs[rs_addr];
		if (rt_addr != '0)
			rt_data = regs[rt_addr];
	end

endmodule

`default_nettype wire

// ==== control.sv ====
`timescale 1ns/1ns
`default_nettype none

module control (
	input  wire decode_pkg::opcode_t   opcode,
	input  wire decode_pkg::funct_t    funct,
	output decode_pkg::exec_bus_t      execute_bus,
	output decode_pkg::mem_bus_t       memory_bus,
	output decode_pkg::wb_bus_t        writeback_bus
);

	decode_pkg::exec_bus_t exec_flags; // Low four bits stay zero
	decode_pkg::aluop_t    aluop;
	decode_pkg::alu_code_t alu_code;

	alu_control u_alu_control (
		.funct    (funct),
		.aluop    (aluop),
		.alu_code (alu_code)
	);

	// ALU code fills the low nibble
	assign execute_bus = exec_flags | decode_pkg::exec_bus_t'(alu_code);

	////////////////////////////////////////
	// Main decode
	////////////////////////////////////////
	always_comb
	begin
		exec_flags    = '0;
		memory_bus    = '0;
		writeback_bus = '0;
		aluop         = decode_pkg::AOP_FUNCT;

		case (opcode)
			decode_pkg::OP_RTYPE:
			begin
				case (funct)
					decode_pkg::F_SLL, decode_pkg::F_SRL, decode_pkg::F_SRA:
					begin // Shift by shamt
						exec_flags[decode_pkg::EX_REG_DST]      = 1'b1;
						exec_flags[decode_pkg::EX_ALU_SRC1]     = 1'b1;
						writeback_bus[decode_pkg::WB_REG_WRITE] = 1'b1;
					end
					decode_pkg::F_JR:
					begin
						exec_flags[decode_pkg::EX_JUMP_REG] = 1'b1; // No write back
					end
					decode_pkg::F_JALR:
					begin
						exec_flags[decode_pkg::EX_JAL_LINK]     = 1'b1;
						exec_flags[decode_pkg::EX_REG_DST]      = 1'b1;
						exec_flags[decode_pkg::EX_JUMP_REG]     = 1'b1;
						writeback_bus[decode_pkg::WB_REG_WRITE] = 1'b1;
					end
					default:
					begin
						exec_flags[decode_pkg::EX_REG_DST]      = 1'b1;
						writeback_bus[decode_pkg::WB_REG_WRITE] = 1'b1;
					end
				endcase
			end

			// Loads
			decode_pkg::OP_LB, decode_pkg::OP_LH, decode_pkg::OP_LW,
			decode_pkg::OP_LBU, decode_pkg::OP_LHU, decode_pkg::OP_LWU:
			begin
				exec_flags[decode_pkg::EX_ALU_SRC2] = 1'b1;
				aluop                               = decode_pkg::AOP_ADD;
				memory_bus[decode_pkg::MEM_READ]    = 1'b1;
				memory_bus[decode_pkg::MEM_LB]      = (opcode == decode_pkg::OP_LB) ||
					(opcode == decode_pkg::OP_LBU);
				memory_bus[decode_pkg::MEM_LH]      = (opcode == decode_pkg::OP_LH) ||
					(opcode == decode_pkg::OP_LHU);
				memory_bus[decode_pkg::MEM_UNSIGNED] = (opcode == decode_pkg::OP_LBU) ||
					(opcode == decode_pkg::OP_LHU);
				writeback_bus = {1'b1, 1'b1}; // Reg write from memory
			end

			// Stores
			decode_pkg::OP_SB, decode_pkg::OP_SH, decode_pkg::OP_SW:
			begin
				exec_flags[decode_pkg::EX_ALU_SRC2] = 1'b1;
				aluop                               = decode_pkg::AOP_ADD;
				memory_bus[decode_pkg::MEM_WRITE]   = 1'b1;
				memory_bus[decode_pkg::MEM_SB]      = (opcode == decode_pkg::OP_SB);
				memory_bus[decode_pkg::MEM_SH]      = (opcode == decode_pkg::OP_SH);
			end

			// Immediate ALU group
			decode_pkg::OP_ADDI, decode_pkg::OP_ANDI, decode_pkg::OP_ORI,
			decode_pkg::OP_XORI, decode_pkg::OP_LUI:
			begin
				exec_flags[decode_pkg::EX_ALU_SRC2]     = 1'b1;
				memory_bus[decode_pkg::MEM_BRANCH]      = 1'b1;
				writeback_bus[decode_pkg::WB_REG_WRITE] = 1'b1;
				case (opcode)
					decode_pkg::OP_ANDI: aluop = decode_pkg::AOP_AND;
					decode_pkg::OP_ORI:  aluop = decode_pkg::AOP_OR;
					decode_pkg::OP_XORI: aluop = decode_pkg::AOP_XOR;
					decode_pkg::OP_LUI:  aluop = decode_pkg::AOP_LUI;
					default:             aluop = decode_pkg::AOP_ADD;
				endcase
			end
			decode_pkg::OP_SLTI:
			begin
				exec_flags[decode_pkg::EX_ALU_SRC2]     = 1'b1;
				aluop                                   = decode_pkg::AOP_SLT;
				writeback_bus[decode_pkg::WB_REG_WRITE] = 1'b1;
			end

			// Branches compare through the ALU
			decode_pkg::OP_BEQ:
			begin
				aluop                              = decode_pkg::AOP_SLT;
				memory_bus[decode_pkg::MEM_BRANCH] = 1'b1;
			end
			decode_pkg::OP_BNE:
			begin
				aluop                              = decode_pkg::AOP_SLT;
				memory_bus[decode_pkg::MEM_BRANCH] = 1'b1;
				memory_bus[decode_pkg::MEM_BNE]    = 1'b1;
			end

			// Jumps
			decode_pkg::OP_J:
			begin
				exec_flags[decode_pkg::EX_JUMP]    = 1'b1;
				memory_bus[decode_pkg::MEM_BRANCH] = 1'b1;
			end
			decode_pkg::OP_JAL:
			begin
				exec_flags[decode_pkg::EX_JAL_LINK]     = 1'b1;
				exec_flags[decode_pkg::EX_JAL_ONLY]     = 1'b1; // Link into r31
				exec_flags[decode_pkg::EX_JUMP]         = 1'b1;
				aluop                                   = decode_pkg::AOP_ADD;
				writeback_bus[decode_pkg::WB_REG_WRITE] = 1'b1;
			end

			default:
			begin
				aluop = decode_pkg::AOP_FUNCT; // Unknown opcode gives a bubble
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== alu_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_control (
	input  wire decode_pkg::funct_t    funct,
	input  wire decode_pkg::aluop_t    aluop,
	output decode_pkg::alu_code_t      alu_code
);

	decode_pkg::alu_code_t funct_code;

	// R-type operation from the function field
	always_comb
	begin
		case (funct)
			decode_pkg::F_SLL:  funct_code = decode_pkg::ALU_SLL;
			decode_pkg::F_SRL:  funct_code = decode_pkg::ALU_SRL;
			decode_pkg::F_SRA:  funct_code = decode_pkg::ALU_SRA;
			decode_pkg::F_SLLV: funct_code = decode_pkg::ALU_SLLV;
			decode_pkg::F_SRLV: funct_code = decode_pkg::ALU_SRLV;
			decode_pkg::F_SRAV: funct_code = decode_pkg::ALU_SRAV;
			decode_pkg::F_ADD,
			decode_pkg::F_ADDU: funct_code = decode_pkg::ALU_ADD;
			decode_pkg::F_SUB,
			decode_pkg::F_SUBU: funct_code = decode_pkg::ALU_SUB;
			decode_pkg::F_AND:  funct_code = decode_pkg::ALU_AND;
			decode_pkg::F_OR:   funct_code = decode_pkg::ALU_OR;
			decode_pkg::F_XOR:  funct_code = decode_pkg::ALU_XOR;
			decode_pkg::F_NOR:  funct_code = decode_pkg::ALU_NOR;
			decode_pkg::F_SLT:  funct_code = decode_pkg::ALU_SLT;
			default:            funct_code = decode_pkg::ALU_ADD; // JR, JALR and unknowns
		endcase
	end

	// Fixed classes bypass the funct table
	always_comb
	begin
		case (aluop)
			decode_pkg::AOP_FUNCT: alu_code = funct_code;
			decode_pkg::AOP_ADD:   alu_code = decode_pkg::ALU_ADD;
			decode_pkg::AOP_AND:   alu_code = decode_pkg::ALU_AND;
			decode_pkg::AOP_OR:    alu_code = decode_pkg::ALU_OR;
			decode_pkg::AOP_XOR:   alu_code = decode_pkg::ALU_XOR;
			decode_pkg::AOP_SLT:   alu_code = decode_pkg::ALU_SLT;
			decode_pkg::AOP_LUI:   alu_code = decode_pkg::ALU_LUI;
			default:               alu_code = decode_pkg::ALU_ADD;
		endcase
	end

endmodule

`default_nettype wire

// ==== decode_pkg.sv ====
`default_nettype none

package decode_pkg;

	////////////////////////////////////////
	// Widths and vector types
	////////////////////////////////////////
	localparam int LEN_WORD     = 32;
	localparam int LEN_REG_ADDR = 5;
	localparam int LEN_OPCODE   = 6;
	localparam int LEN_FUNCT    = 6;
	localparam int LEN_EXEC_BUS = 11;
	localparam int LEN_MEM_BUS  = 9;
	localparam int LEN_WB_BUS   = 2;
	localparam int LEN_ALU_CODE = 4;
	localparam int LEN_ALUOP    = 3;
	localparam int N_REGS       = 32; // Register 0 included

	typedef logic [LEN_WORD-1:0]     word_t;
	typedef logic [LEN_REG_ADDR-1:0] reg_addr_t;
	typedef logic [LEN_OPCODE-1:0]   opcode_t;
	typedef logic [LEN_FUNCT-1:0]    funct_t;
	typedef logic [LEN_EXEC_BUS-1:0] exec_bus_t;
	typedef logic [LEN_MEM_BUS-1:0]  mem_bus_t;
	typedef logic [LEN_WB_BUS-1:0]   wb_bus_t;
	typedef logic [LEN_ALU_CODE-1:0] alu_code_t;
	typedef logic [LEN_ALUOP-1:0]    aluop_t;

	////////////////////////////////////////
	// Control bus bit positions
	////////////////////////////////////////
	// ALU code sits in execute bus [3:0]
	localparam int EX_JAL_LINK = 10;
	localparam int EX_JAL_ONLY = 9;
	localparam int EX_REG_DST  = 8;
	localparam int EX_ALU_SRC1 = 7; // Shamt as first operand
	localparam int EX_ALU_SRC2 = 6; // Immediate as second operand
	localparam int EX_JUMP     = 5;
	localparam int EX_JUMP_REG = 4;

	localparam int MEM_BNE      = 8;
	localparam int MEM_SB       = 7;
	localparam int MEM_SH       = 6;
	localparam int MEM_LB       = 5;
	localparam int MEM_LH       = 4;
	localparam int MEM_UNSIGNED = 3;
	localparam int MEM_BRANCH   = 2;
	localparam int MEM_READ     = 1;
	localparam int MEM_WRITE    = 0;

	localparam int WB_REG_WRITE  = 1;
	localparam int WB_MEM_TO_REG = 0;

	////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////
	localparam opcode_t OP_RTYPE = 6'b000000;
	localparam opcode_t OP_LB    = 6'b100000;
	localparam opcode_t OP_LH    = 6'b100001;
	localparam opcode_t OP_LW    = 6'b100011;
	localparam opcode_t OP_LBU   = 6'b100100;
	localparam opcode_t OP_LHU   = 6'b100101;
	localparam opcode_t OP_LWU   = 6'b100111;
	localparam opcode_t OP_SB    = 6'b101000;
	localparam opcode_t OP_SH    = 6'b101001;
	localparam opcode_t OP_SW    = 6'b101011;
	localparam opcode_t OP_ADDI  = 6'b001000;
	localparam opcode_t OP_ANDI  = 6'b001100;
	localparam opcode_t OP_ORI   = 6'b001101;
	localparam opcode_t OP_XORI  = 6'b001110;
	localparam opcode_t OP_LUI   = 6'b001111;
	localparam opcode_t OP_SLTI  = 6'b001010;
	localparam opcode_t OP_BEQ   = 6'b000100;
	localparam opcode_t OP_BNE   = 6'b000101;
	localparam opcode_t OP_J     = 6'b000010;
	localparam opcode_t OP_JAL   = 6'b000011;

	// R-type function field
	localparam funct_t F_SLL  = 6'b000000;
	localparam funct_t F_SRL  = 6'b000010;
	localparam funct_t F_SRA  = 6'b000011;
	localparam funct_t F_SLLV = 6'b000100;
	localparam funct_t F_SRLV = 6'b000110;
	localparam funct_t F_SRAV = 6'b000111;
	localparam funct_t F_JR   = 6'b001000;
	localparam funct_t F_JALR = 6'b001001;
	localparam funct_t F_ADD  = 6'b100000;
	localparam funct_t F_ADDU = 6'b100001;
	localparam funct_t F_SUB  = 6'b100010;
	localparam funct_t F_SUBU = 6'b100011;
	localparam funct_t F_AND  = 6'b100100;
	localparam funct_t F_OR   = 6'b100101;
	localparam funct_t F_XOR  = 6'b100110;
	localparam funct_t F_NOR  = 6'b100111;
	localparam funct_t F_SLT  = 6'b101010;

	////////////////////////////////////////
	// ALU classes and codes
	////////////////////////////////////////
	localparam aluop_t AOP_FUNCT = 3'd0; // Decode from funct
	localparam aluop_t AOP_ADD   = 3'd1;
	localparam aluop_t AOP_AND   = 3'd2;
	localparam aluop_t AOP_OR    = 3'd3;
	localparam aluop_t AOP_XOR   = 3'd4;
	localparam aluop_t AOP_SLT   = 3'd6;
	localparam aluop_t AOP_LUI   = 3'd7;

	localparam alu_code_t ALU_SLL  = 4'd0;
	localparam alu_code_t ALU_SRL  = 4'd1;
	localparam alu_code_t ALU_SRA  = 4'd2;
	localparam alu_code_t ALU_SLLV = 4'd3;
	localparam alu_code_t ALU_SRLV = 4'd4;
	localparam alu_code_t ALU_SRAV = 4'd5;
	localparam alu_code_t ALU_ADD  = 4'd6; // Also the fallback
	localparam alu_code_t ALU_SUB  = 4'd7;
	localparam alu_code_t ALU_AND  = 4'd8;
	localparam alu_code_t ALU_OR   = 4'd9;
	localparam alu_code_t ALU_XOR  = 4'd10;
	localparam alu_code_t ALU_NOR  = 4'd11;
	localparam alu_code_t ALU_SLT  = 4'd12;
	localparam alu_code_t ALU_LUI  = 4'd13;

endpackage

`default_nettype wire
